// ==== build.f ====
source/yaw_ctrl_pkg.sv
source/yaw_angle_accumulator.sv
source/yaw_rate_controller.sv
source/yaw_cycle_sequencer.sv
source/yaw_control_top.sv
tb/yaw_control_tb.sv

// ==== source/yaw_angle_accumulator.sv ====
// yaw angle accumulator
// tracks the body yaw target from the yaw stick with wrap at 360 degrees
// and computes the shortest way error between target and imu yaw
`timescale 1ns/1ps

module yaw_angle_accumulator #(
	parameter int throttle_off_level = 10
) (
	input  logic                                       us_clk,
	input  logic                                       resetn,
	input  logic                                       start,
	input  logic [yaw_ctrl_pkg::rec_val_width-1:0]     throttle_value,
	input  logic [yaw_ctrl_pkg::rec_val_width-1:0]     yaw_value,
	input  logic signed [yaw_ctrl_pkg::rate_width-1:0] yaw_angle_imu,
	output logic signed [yaw_ctrl_pkg::rate_width-1:0] body_yaw_angle_target,
	output logic signed [yaw_ctrl_pkg::rate_width-1:0] yaw_angle_error,
	output logic                                       active,
	output logic                                       complete
);
	import yaw_ctrl_pkg::*;

	// one-hot state encoding
	localparam logic [4:0] st_waiting  = 5'b00001;
	localparam logic [4:0] st_track    = 5'b00010;
	localparam logic [4:0] st_body     = 5'b00100;
	localparam logic [4:0] st_error    = 5'b01000;
	localparam logic [4:0] st_complete = 5'b10000;

	logic [4:0] state;
	logic [4:0] next_state;
	logic       start_flag;

	// inputs captured at the start of a cycle
	logic [rec_val_width-1:0]      throttle_lat;
	logic signed [rec_val_width:0] yaw_lat;      // one extra bit keeps it positive
	logic signed [rate_width-1:0]  imu_lat;

	logic signed [track_width-1:0] tracking;
	logic signed [track_width-1:0] track_sum;
	logic                          throttle_off;

	assign throttle_off = (throttle_lat < throttle_off_level);

	// stick offset from centre added to the running target
	assign track_sum = tracking + (yaw_lat - stick_centre);

	// hold the start request until the machine has taken it
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			start_flag <= 1'b0;
		end else if (start && !start_flag) begin
			start_flag <= 1'b1;
		end else if (!start && start_flag && (state != st_waiting)) begin
			start_flag <= 1'b0;
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn)
			state <= st_waiting;
		else
			state <= next_state;
	end

	always_comb begin
		case (state)
			st_waiting:  next_state = start_flag ? st_track : st_waiting;
			st_track:    next_state = st_body;
			st_body:     next_state = st_error;
			st_error:    next_state = st_complete;
			st_complete: next_state = st_waiting;
			default:     next_state = st_waiting;
		endcase
	end

	// latch receiver and imu values when a cycle begins
	always_ff @(posedge us_clk) begin
		if ((state == st_waiting) && start_flag) begin
			throttle_lat <= throttle_value;
			yaw_lat      <= {1'b0, yaw_value};
			imu_lat      <= yaw_angle_imu;
		end
	end

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			tracking              <= '0;
			body_yaw_angle_target <= '0;
			yaw_angle_error       <= '0;
		end else begin
			case (state)
				st_track: begin
					if (throttle_off)
						tracking <= track_width'(imu_lat) <<< track_shift; // restart from imu
					else if (track_sum > track_360)
						tracking <= track_sum - track_360;
					else if (track_sum < angle_0)
						tracking <= track_sum + track_360;
					else
						tracking <= track_sum;
				end
				st_body: begin
					if (throttle_off)
						body_yaw_angle_target <= imu_lat;
					else
						body_yaw_angle_target <= rate_width'(tracking >>> track_shift);
				end
				st_error: begin
					// take the short way round when the two angles straddle 0 degrees
					if (throttle_off)
						yaw_angle_error <= '0;
					else if ((body_yaw_angle_target > angle_270) && (imu_lat < angle_90))
						yaw_angle_error <= rate_width'(body_yaw_angle_target - angle_360 - imu_lat);
					else if ((imu_lat > angle_270) && (body_yaw_angle_target < angle_90))
						yaw_angle_error <= rate_width'(angle_360 - imu_lat + body_yaw_angle_target);
					else
						yaw_angle_error <= body_yaw_angle_target - imu_lat;
				end
				default: begin
					tracking <= tracking;
				end
			endcase
		end
	end

	assign active   = (state == st_track) || (state == st_body) || (state == st_error);
	assign complete = (state == st_complete); // one cycle per pass through the machine

	a_state_onehot: assert property (@(posedge us_clk) disable iff (!resetn)
		$onehot(state))
		else $error("accumulator state is not one-hot: %b", state);

	a_complete_pulse: assert property (@(posedge us_clk) disable iff (!resetn)
		complete |=> !complete)
		else $error("accumulator complete held longer than one cycle");

endmodule

// ==== source/yaw_control_top.sv ====
// yaw control channel top level
// sequencer, angle accumulator and rate controller for one control frame
`timescale 1ns/1ps

module yaw_control_top #(
	parameter int throttle_off_level = 10,
	parameter int kp                 = 3,
	parameter int ki_shift           = 4,
	parameter int integ_limit        = 8000,
	parameter int rate_limit         = 4000
) (
	input  logic                                       us_clk,
	input  logic                                       resetn,
	input  logic                                       sample_tick,
	input  logic [yaw_ctrl_pkg::rec_val_width-1:0]     throttle_value,
	input  logic [yaw_ctrl_pkg::rec_val_width-1:0]     yaw_value,
	input  logic signed [yaw_ctrl_pkg::rate_width-1:0] yaw_angle_imu,
	output logic signed [yaw_ctrl_pkg::rate_width-1:0] body_yaw_angle_target,
	output logic signed [yaw_ctrl_pkg::rate_width-1:0] yaw_angle_error,
	output logic signed [yaw_ctrl_pkg::rate_width-1:0] yaw_rate_cmd,
	output logic                                       busy,
	output logic                                       cycle_done,
	output logic                                       overrun
);

	logic acc_start;
	logic acc_complete;
	logic ctl_start;
	logic ctl_done;

	yaw_cycle_sequencer u_seq (
		.us_clk       (us_clk),
		.resetn       (resetn),
		.sample_tick  (sample_tick),
		.acc_complete (acc_complete),
		.ctl_done     (ctl_done),
		.acc_start    (acc_start),
		.ctl_start    (ctl_start),
		.busy         (busy),
		.cycle_done   (cycle_done),
		.overrun      (overrun)
	);

	yaw_angle_accumulator #(
		.throttle_off_level (throttle_off_level)
	) u_acc (
		.us_clk                (us_clk),
		.resetn                (resetn),
		.start                 (acc_start),
		.throttle_value        (throttle_value),
		.yaw_value             (yaw_value),
		.yaw_angle_imu         (yaw_angle_imu),
		.body_yaw_angle_target (body_yaw_angle_target),
		.yaw_angle_error       (yaw_angle_error),
		.active                (),            // sequencer tracks progress by pulses
		.complete              (acc_complete)
	);

	// error feeds the rate stage and is also visible outside
	yaw_rate_controller #(
		.kp          (kp),
		.ki_shift    (ki_shift),
		.integ_limit (integ_limit),
		.rate_limit  (rate_limit)
	) u_ctl (
		.us_clk      (us_clk),
		.resetn      (resetn),
		.start       (ctl_start),
		.angle_error (yaw_angle_error),
		.rate_cmd    (yaw_rate_cmd),
		.done        (ctl_done)
	);

endmodule

// ==== source/yaw_ctrl_pkg.sv ====
// yaw control shared definitions
// widths, fixed point layout, angle constants and the yaw stick centre
// angles and rates are signed 12.4 fixed point with 1/16 degree per lsb

package yaw_ctrl_pkg;

	// receiver stick values run from 0 to 250
	localparam int rec_val_width = 8;

	// angles, errors and rate commands
	localparam int rate_width = 16;
	localparam int frac_bits  = 4; // fractional bits in a rate_width value

	// tracking accumulator holds the target angle scaled by 4
	localparam int track_width = 32;
	localparam int track_shift = 2;

	// angle constants in 1/16 degree
	localparam int angle_360 = 5760;
	localparam int angle_270 = 4320;
	localparam int angle_90  = 1440;
	localparam int angle_0   = 0;

	// full turn in tracking units
	localparam int track_360 = angle_360 << track_shift;

	// stick position that commands zero yaw rate
	localparam int stick_centre = 125;

endpackage

// ==== source/yaw_cycle_sequencer.sv ====
// yaw control cycle sequencer
// runs the accumulator then the rate controller once per sample tick
// and flags ticks that arrive while a cycle is still running
`timescale 1ns/1ps

module yaw_cycle_sequencer (
	input  logic us_clk,
	input  logic resetn,
	input  logic sample_tick,
	input  logic acc_complete,
	input  logic ctl_done,
	output logic acc_start,
	output logic ctl_start,
	output logic busy,
	output logic cycle_done,
	output logic overrun
);

	localparam logic [1:0] s_idle     = 2'd0;
	localparam logic [1:0] s_wait_acc = 2'd1;
	localparam logic [1:0] s_wait_ctl = 2'd2;

	logic [1:0] state;

	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			state     <= s_idle;
			acc_start <= 1'b0;
			ctl_start <= 1'b0;
			overrun   <= 1'b0;
		end else begin
			acc_start <= 1'b0;
			ctl_start <= 1'b0;
			if (sample_tick && (state != s_idle))
				overrun <= 1'b1; // sticky until reset, the tick itself is dropped
			case (state)
				s_idle: begin
					if (sample_tick) begin
						acc_start <= 1'b1;
						state     <= s_wait_acc;
					end
				end
				s_wait_acc: begin
					if (acc_complete) begin
						ctl_start <= 1'b1;
						state     <= s_wait_ctl;
					end
				end
				s_wait_ctl: begin
					if (ctl_done)
						state <= s_idle;
				end
				default: state <= s_idle;
			endcase
		end
	end

	assign busy       = (state != s_idle);
	assign cycle_done = (state == s_wait_ctl) && ctl_done; // outputs are all valid here

	a_acc_start_idle: assert property (@(posedge us_clk) disable iff (!resetn)
		acc_start |-> ($past(state) == s_idle))
		else $error("acc_start issued outside idle");

endmodule

// ==== source/yaw_rate_controller.sv ====
// yaw rate controller
// proportional-integral stage from yaw angle error to a yaw rate command
// integrator and output are both clamped to symmetric limits
`timescale 1ns/1ps

module yaw_rate_controller #(
	parameter int kp          = 3,
	parameter int ki_shift    = 4,
	parameter int integ_limit = 8000,
	parameter int rate_limit  = 4000
) (
	input  logic                                       us_clk,
	input  logic                                       resetn,
	input  logic                                       start,
	input  logic signed [yaw_ctrl_pkg::rate_width-1:0] angle_error,
	output logic signed [yaw_ctrl_pkg::rate_width-1:0] rate_cmd,
	output logic                                       done
);
	import yaw_ctrl_pkg::*;

	localparam logic signed [track_width-1:0] integ_max = track_width'(integ_limit);
	localparam logic signed [track_width-1:0] integ_min = -track_width'(integ_limit);
	localparam logic signed [track_width-1:0] rate_max  = track_width'(rate_limit);
	localparam logic signed [track_width-1:0] rate_min  = -track_width'(rate_limit);

	logic signed [rate_width-1:0]  integ;
	logic signed [rate_width-1:0]  integ_next;
	logic signed [track_width-1:0] integ_sum;
	logic signed [track_width-1:0] prod;       // kp times error, still 12.4
	logic signed [track_width-1:0] pi_sum;
	logic signed [track_width-1:0] pi_scaled;
	logic signed [rate_width-1:0]  rate_next;
	logic                          calc_pending;

	// integrator update with anti windup clamp
	assign integ_sum = track_width'(integ) + track_width'(angle_error);

	always_comb begin
		if (integ_sum > integ_max)
			integ_next = rate_width'(integ_max);
		else if (integ_sum < integ_min)
			integ_next = rate_width'(integ_min);
		else
			integ_next = rate_width'(integ_sum);
	end

	// p term plus scaled i term, fraction dropped
	assign pi_sum    = prod + (track_width'(integ) >>> ki_shift);
	assign pi_scaled = pi_sum >>> frac_bits;

	always_comb begin
		if (pi_scaled > rate_max)
			rate_next = rate_width'(rate_max);
		else if (pi_scaled < rate_min)
			rate_next = rate_width'(rate_min);
		else
			rate_next = rate_width'(pi_scaled);
	end

	always_ff @(posedge us_clk) begin
		if (start)
			prod <= track_width'(angle_error) * kp;
	end

	// first edge updates integrator and product, second one registers the command
	always_ff @(posedge us_clk or negedge resetn) begin
		if (!resetn) begin
			integ        <= '0;
			calc_pending <= 1'b0;
			rate_cmd     <= '0;
			done         <= 1'b0;
		end else begin
			calc_pending <= start;
			done         <= calc_pending;
			if (start)
				integ <= integ_next;
			if (calc_pending)
				rate_cmd <= rate_next;
		end
	end

	a_rate_bounded: assert property (@(posedge us_clk) disable iff (!resetn)
		(rate_cmd <= rate_limit) && (rate_cmd >= -rate_limit))
		else $error("rate_cmd %0d outside +/-%0d", rate_cmd, rate_limit);

endmodule

// ==== tb/yaw_control_tb.sv ====
// yaw control channel testbench
// reference model of tracking, error wrap and the PI stage, checked by assertions
// directed reset, throttle off, wrap, saturation and overrun cases plus random frames
`timescale 1ns/1ps

module yaw_control_tb;
	import yaw_ctrl_pkg::*;

	// DUT defaults mirrored for the model
	localparam int off_level = 10;
	localparam int gain_p    = 3;
	localparam int gain_i_sh = 4;
	localparam int integ_max = 8000;
	localparam int rate_max  = 4000;
	localparam int max_wait  = 50;

	logic                         us_clk;
	logic                         resetn;
	logic                         sample_tick;
	logic [rec_val_width-1:0]     throttle_value;
	logic [rec_val_width-1:0]     yaw_value;
	logic signed [rate_width-1:0] yaw_angle_imu;
	logic signed [rate_width-1:0] body_yaw_angle_target;
	logic signed [rate_width-1:0] yaw_angle_error;
	logic signed [rate_width-1:0] yaw_rate_cmd;
	logic                         busy;
	logic                         cycle_done;
	logic                         overrun;

	int model_track = 0;
	int model_integ = 0;
	int exp_target  = 0;
	int exp_error   = 0;
	int exp_rate    = 0;
	int done_count  = 0;
	integer seed;

	// target and imu pairs around the 90 and 270 degree boundaries
	int pair_target [6] = '{5000, 300, 4400, 4320, 1500, 1439};
	int pair_imu    [6] = '{200, 5500, 1400, 100, 5000, 4321};

	yaw_control_top uut (
		.us_clk                (us_clk),
		.resetn                (resetn),
		.sample_tick           (sample_tick),
		.throttle_value        (throttle_value),
		.yaw_value             (yaw_value),
		.yaw_angle_imu         (yaw_angle_imu),
		.body_yaw_angle_target (body_yaw_angle_target),
		.yaw_angle_error       (yaw_angle_error),
		.yaw_rate_cmd          (yaw_rate_cmd),
		.busy                  (busy),
		.cycle_done            (cycle_done),
		.overrun               (overrun)
	);

	always #2 us_clk = ~us_clk;

	always @(negedge us_clk) begin
		if (cycle_done)
			done_count++;
	end

	task automatic fail_value(input string name, input int exp, input int act);
		$display("Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic fail_plain(input string what);
		$display("%0t ns: %s", $time, what);
		$display("=== FAIL ===");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input int exp, input int act);
		assert (act == exp) else fail_value(name, exp, act);
	endtask

	function automatic int clamp(input int v, input int lim);
		if (v > lim)
			return lim;
		else if (v < -lim)
			return -lim;
		return v;
	endfunction

	// reference model of one full control cycle
	task automatic predict(input int thr, input int yaw, input int imu);
		int sum;
		int pi_term;
		if (thr < off_level) begin
			model_track = imu * 4;
			exp_target  = imu;
			exp_error   = 0;
		end else begin
			sum = model_track + yaw - stick_centre;
			if (sum > track_360)
				sum = sum - track_360;
			else if (sum < 0)
				sum = sum + track_360;
			model_track = sum;
			exp_target  = model_track >>> 2;
			if ((exp_target > angle_270) && (imu < angle_90))
				exp_error = exp_target - angle_360 - imu; // target just below 360
			else if ((imu > angle_270) && (exp_target < angle_90))
				exp_error = angle_360 - imu + exp_target;
			else
				exp_error = exp_target - imu;
		end
		model_integ = clamp(model_integ + exp_error, integ_max);
		pi_term     = (gain_p * exp_error + (model_integ >>> gain_i_sh)) >>> 4;
		exp_rate    = clamp(pi_term, rate_max);
	endtask

	task automatic pulse_tick();
		sample_tick = 1'b1;
		@(posedge us_clk);
		#1;
		sample_tick = 1'b0;
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		@(negedge us_clk);
		while (!cycle_done) begin
			n++;
			if (n > max_wait)
				fail_plain("timeout waiting for cycle_done");
			@(negedge us_clk);
		end
	endtask

	// called 1 ns after a rising edge, returns at the same phase
	task automatic run_cycle(input int thr, input int yaw, input int imu);
		throttle_value = thr;
		yaw_value      = yaw;
		yaw_angle_imu  = imu;
		predict(thr, yaw, imu);
		pulse_tick();
		wait_done();
		@(posedge us_clk);
		#1;
	endtask

	a_target: assert property (@(posedge us_clk) disable iff (!resetn)
		cycle_done |-> (body_yaw_angle_target == exp_target))
		else fail_value("body_yaw_angle_target", exp_target, $sampled(body_yaw_angle_target));

	a_error: assert property (@(posedge us_clk) disable iff (!resetn)
		cycle_done |-> (yaw_angle_error == exp_error))
		else fail_value("yaw_angle_error", exp_error, $sampled(yaw_angle_error));

	a_rate: assert property (@(posedge us_clk) disable iff (!resetn)
		cycle_done |-> (yaw_rate_cmd == exp_rate))
		else fail_value("yaw_rate_cmd", exp_rate, $sampled(yaw_rate_cmd));

	// accepted tick gives busy for 8 cycles, then a single done pulse
	a_cycle_timing: assert property (@(posedge us_clk) disable iff (!resetn)
		(sample_tick && !busy) |=> (busy && !cycle_done)[*8] ##1 (busy && cycle_done))
		else fail_plain("busy or cycle_done timing wrong after sample_tick");

	a_done_single: assert property (@(posedge us_clk) disable iff (!resetn)
		cycle_done |=> !cycle_done)
		else fail_plain("cycle_done lasted more than one cycle");

	a_overrun_set: assert property (@(posedge us_clk) disable iff (!resetn)
		(sample_tick && busy) |=> overrun)
		else fail_plain("overrun not set by a tick while busy");

	a_overrun_sticky: assert property (@(posedge us_clk) disable iff (!resetn)
		overrun |=> overrun)
		else fail_plain("overrun dropped before reset");

	initial begin
		us_clk         = 1'b0;
		resetn         = 1'b0;
		sample_tick    = 1'b0;
		throttle_value = '0;
		yaw_value      = 8'd125;
		yaw_angle_imu  = '0;
		seed           = 32'hd52a;
		repeat (5) @(posedge us_clk);
		#1;
		resetn = 1'b1;
		@(posedge us_clk);
		#1;
		check_value("busy", 0, busy);
		check_value("cycle_done", 0, cycle_done);
		check_value("overrun", 0, overrun);
		check_value("body_yaw_angle_target", 0, body_yaw_angle_target);
		check_value("yaw_angle_error", 0, yaw_angle_error);
		check_value("yaw_rate_cmd", 0, yaw_rate_cmd);

		run_cycle(5, 200, 1000); // throttle off, target follows imu
		run_cycle(0, 30, 4700);

		// start near 360 then push past it and back below 0
		run_cycle(5, 125, 5700);
		repeat (4) run_cycle(100, 250, 5700);
		repeat (4) run_cycle(100, 0, 100);

		for (int i = 0; i < 6; i++) begin
			run_cycle(5, 125, pair_target[i]);
			run_cycle(100, 125, pair_imu[i]);
		end

		// large errors both ways to hit the integrator clamp
		run_cycle(5, 125, 2880);
		repeat (4) run_cycle(100, 125, 0);
		run_cycle(5, 125, 0);
		repeat (6) run_cycle(100, 125, 2880);
		run_cycle(5, 125, 3000); // integrator term only

		for (int i = 0; i < 24; i++) begin
			int thr;
			int yaw;
			int imu;
			thr = (({$random(seed)} % 4) == 0) ? 3 : 60 + ({$random(seed)} % 190);
			yaw = {$random(seed)} % 251;
			imu = {$random(seed)} % angle_360;
			run_cycle(thr, yaw, imu);
		end

		// second tick while busy must be dropped
		begin
			int count_before;
			count_before = done_count;
			throttle_value = 100;
			yaw_value      = 140;
			yaw_angle_imu  = 2000;
			predict(100, 140, 2000);
			pulse_tick();
			repeat (3) @(posedge us_clk);
			#1;
			pulse_tick();
			wait_done();
			repeat (20) @(posedge us_clk);
			#1;
			check_value("cycle_done count", count_before + 1, done_count);
			check_value("overrun", 1, overrun);
		end

		$display("=== PASS ===");
		$finish;
	end

endmodule
